//--- design/dbg_pkg.sv
package dbg_pkg;

	//////////////////////////////////////////////////////////////////////
	// Debug bus widths
	//////////////////////////////////////////////////////////////////////

	localparam int DATA_W = 32;
	localparam int ADDR_W = 6;
	localparam int REG_AW = 5;
	localparam int SEL_W = DATA_W / 8;

	// Top address bit picks the space
	localparam logic ADDR_CTRL = 1'b0;
	localparam logic ADDR_CPU = 1'b1;

	//////////////////////////////////////////////////////////////////////
	// Control and status word layout
	//////////////////////////////////////////////////////////////////////

	// Control bits, all within byte 0
	localparam int HALT_BIT = 0;
	localparam int STEP_BIT = 2;
	localparam int RESET_BIT = 3;
	localparam int CATCH_BIT = 5;

	// Status only bits
	localparam int STAT_HALTED_BIT = 1;
	localparam int STAT_INT_BIT = 10;
	localparam int STAT_BREAK_BIT = 11;

	// Cycle counts, sized to their counters
	localparam logic [3:0] RESET_DURATION = 4'd10;
	localparam logic [1:0] READ_WAIT = 2'd2;

	// Core model
	localparam int PC_REG = 31;
	localparam logic [DATA_W-1:0] RESET_PC = 32'h1000_0000;

	//////////////////////////////////////////////////////////////////////
	// Structs between blocks
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic			we;
		logic [ADDR_W-1:0]	addr;
		logic [DATA_W-1:0]	data;
		logic [SEL_W-1:0]	sel;
	} dbg_req_t;

	typedef struct packed {
		logic			reset;
		logic			halt;
		logic			wr;
		logic [REG_AW-1:0]	waddr;
		logic [DATA_W-1:0]	wdata;
	} core_cmd_t;

	// Write stall means a debug write is waiting on the halt
	typedef struct packed {
		logic	halted;
		logic	wr_stall;
		logic	brk;
	} core_stat_t;

endpackage

//--- design/core_regs.sv
`timescale 1ns/10ps

module core_regs (
	input	logic				i_clk,
	input	dbg_pkg::core_cmd_t		i_cmd,
	input	logic [dbg_pkg::REG_AW-1:0]	i_rreg,
	input	logic				i_fault,
	output	dbg_pkg::core_stat_t		o_stat,
	output	logic [dbg_pkg::DATA_W-1:0]	o_rdata
);

	// Debug side of the core register file
	logic	[dbg_pkg::DATA_W-1:0]	regs [0:(1 << dbg_pkg::REG_AW)-1];
	logic	halted;
	logic	brk;

	//////////////////////////////////////////////////////////////////////
	// Run and halt model
	//////////////////////////////////////////////////////////////////////

	// Halt takes one cycle to land
	always_ff @(posedge i_clk)
	begin
		halted <= i_cmd.halt;
	end

	// Faults only count while running
	always_ff @(posedge i_clk)
	begin
		brk <= !i_cmd.reset && !halted && i_fault;
	end

	//////////////////////////////////////////////////////////////////////
	// Register bank
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		// Debug write only lands on a stopped core
		if (i_cmd.wr && halted)
			regs[i_cmd.waddr] <= i_cmd.wdata;
		// PC restarts on reset, else ticks while running
		if (i_cmd.reset)
			regs[dbg_pkg::PC_REG] <= dbg_pkg::RESET_PC;
		else if (!halted)
			regs[dbg_pkg::PC_REG] <= regs[dbg_pkg::PC_REG] + 1'b1;
	end

	// Registered read port
	always_ff @(posedge i_clk)
	begin
		o_rdata <= regs[i_rreg];
	end

	// Feedback to the controller
	always_comb
	begin
		o_stat.halted = halted;
		o_stat.wr_stall = i_cmd.wr && !halted;
		o_stat.brk = brk;
	end

endmodule

//--- design/dbg_ctrl.sv
`timescale 1ns/10ps

module dbg_ctrl (
	input	logic				i_clk,
	input	logic				i_reset,
	input	dbg_pkg::dbg_req_t		i_req,
	input	logic				i_accept,
	input	dbg_pkg::core_stat_t		i_stat,
	input	logic				i_ext_int,
	output	dbg_pkg::core_cmd_t		o_cmd,
	output	logic [dbg_pkg::DATA_W-1:0]	o_status
);

	logic	ctrl_write, ctrl_byte0, cpu_write;
	logic	reset_request, release_request, halt_request, step_request;
	logic	[$bits(dbg_pkg::RESET_DURATION)-1:0]	hold_cnt;
	logic	reset_hold;
	logic	cmd_reset, cmd_halt, cmd_step, cmd_write, dbg_catch;
	logic	[dbg_pkg::REG_AW-1:0]	cmd_waddr;
	logic	[dbg_pkg::DATA_W-1:0]	cmd_wdata;

	//////////////////////////////////////////////////////////////////////
	// Command decode
	//////////////////////////////////////////////////////////////////////

	// Control space write, any select
	assign ctrl_write = i_accept && i_req.we
		&& (i_req.addr[dbg_pkg::ADDR_W-1] == dbg_pkg::ADDR_CTRL);
	// Every control bit lives in byte 0
	assign ctrl_byte0 = ctrl_write && i_req.sel[0];
	// Register write needs a full word
	assign cpu_write = i_accept && i_req.we
		&& (i_req.addr[dbg_pkg::ADDR_W-1] == dbg_pkg::ADDR_CPU)
		&& (i_req.sel == '1);

	assign reset_request = ctrl_byte0 && i_req.data[dbg_pkg::RESET_BIT];
	assign release_request = ctrl_byte0 && !i_req.data[dbg_pkg::HALT_BIT];
	assign halt_request = ctrl_byte0 && i_req.data[dbg_pkg::HALT_BIT];
	assign step_request = ctrl_byte0 && i_req.data[dbg_pkg::STEP_BIT];

	// Power-up hold, counts down once after i_reset
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			hold_cnt <= dbg_pkg::RESET_DURATION;
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
	end

	assign reset_hold = (hold_cnt != '0);

	//////////////////////////////////////////////////////////////////////
	// Reset, halt, step and catch
	//////////////////////////////////////////////////////////////////////

	// Unhandled break resets the core
	always_ff @(posedge i_clk)
	begin
		if (i_reset || reset_hold)
			cmd_reset <= 1'b1;
		else if (i_stat.brk && !dbg_catch)
			cmd_reset <= 1'b1;
		else
			cmd_reset <= reset_request;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset || cmd_reset)
			cmd_halt <= 1'b1;
		else
		begin
			// Release only from a full stop with no write pending
			if (!cmd_write && i_stat.halted && (release_request || step_request))
				cmd_halt <= 1'b0;
			// Any break stops, catch decides between halt and reset
			if (i_stat.brk)
				cmd_halt <= 1'b1;
			// Halt bit loses to the step bit
			if (halt_request && !step_request)
				cmd_halt <= 1'b1;
			if (cpu_write)
				cmd_halt <= 1'b1;
			// Back to halted after one stepped cycle
			if (cmd_step && !step_request)
				cmd_halt <= 1'b1;
			// Reset request halts along with the reset pulse
			if (reset_request)
				cmd_halt <= 1'b1;
		end
	end

	// One cycle pulse per step command
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			cmd_step <= 1'b0;
		else if (cmd_reset || i_stat.brk || reset_request)
			cmd_step <= 1'b0;
		else if (!cmd_write && i_stat.halted && step_request)
			cmd_step <= 1'b1;
		else
			cmd_step <= 1'b0;
	end

	// Catch comes up set since the core starts halted
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			dbg_catch <= 1'b1;
		else if (ctrl_byte0)
			dbg_catch <= i_req.data[dbg_pkg::CATCH_BIT];
	end

	//////////////////////////////////////////////////////////////////////
	// Pending register write
	//////////////////////////////////////////////////////////////////////

	// Held until the core reports halted
	always_ff @(posedge i_clk)
	begin
		if (i_reset || cmd_reset)
			cmd_write <= 1'b0;
		else if (!cmd_write || i_stat.halted)
			cmd_write <= cpu_write;
	end

	always_ff @(posedge i_clk)
	begin
		if ((!cmd_write || i_stat.halted) && cpu_write)
		begin
			cmd_waddr <= i_req.addr[dbg_pkg::REG_AW-1:0];
			cmd_wdata <= i_req.data;
		end
	end

	// Core command bundle
	always_comb
	begin
		o_cmd.reset = cmd_reset;
		o_cmd.halt = cmd_halt;
		o_cmd.wr = cmd_write;
		o_cmd.waddr = cmd_waddr;
		o_cmd.wdata = cmd_wdata;
	end

	// Status word, unused bits read zero
	always_comb
	begin
		o_status = '0;
		o_status[dbg_pkg::HALT_BIT] = cmd_halt;
		o_status[dbg_pkg::STAT_HALTED_BIT] = i_stat.halted;
		o_status[dbg_pkg::RESET_BIT] = cmd_reset;
		o_status[dbg_pkg::CATCH_BIT] = dbg_catch;
		o_status[dbg_pkg::STAT_INT_BIT] = i_ext_int;
		o_status[dbg_pkg::STAT_BREAK_BIT] = i_stat.brk;
	end

endmodule

//--- design/dbg_resp.sv
`timescale 1ns/10ps

module dbg_resp (
	input	logic				i_clk,
	input	logic				i_reset,
	input	logic				i_dbg_cyc,
	input	logic				i_dbg_stb,
	input	logic				i_dbg_we,
	input	logic				i_addr_sel,
	input	logic				i_write_wait,
	input	logic [dbg_pkg::DATA_W-1:0]	i_status,
	input	logic [dbg_pkg::DATA_W-1:0]	i_reg_data,
	output	logic				o_accept,
	output	logic				o_dbg_stall,
	output	logic				o_dbg_ack,
	output	logic [dbg_pkg::DATA_W-1:0]	o_dbg_data
);

	logic	cpu_read, cmd_read, pre_ack;
	logic	[$bits(dbg_pkg::READ_WAIT)-1:0]	read_cnt;
	logic	[dbg_pkg::DATA_W-1:0]		status_r;

	//////////////////////////////////////////////////////////////////////
	// Accept and stall
	//////////////////////////////////////////////////////////////////////

	// Stall holds off the bus during a core read
	// and while a write waits for the halt
	assign o_dbg_stall = cmd_read
		|| (i_write_wait && (i_addr_sel == dbg_pkg::ADDR_CPU));
	assign o_accept = i_dbg_stb && !o_dbg_stall;
	assign cpu_read = o_accept && !i_dbg_we
		&& (i_addr_sel == dbg_pkg::ADDR_CPU);

	// Outstanding core read, cleared when cyc drops
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_dbg_cyc)
			cmd_read <= 1'b0;
		else if (cpu_read)
			cmd_read <= 1'b1;
		else if (read_cnt == 'd1)
			cmd_read <= 1'b0;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_dbg_cyc)
			read_cnt <= '0;
		else if (cpu_read)
			read_cnt <= dbg_pkg::READ_WAIT;
		else if (read_cnt != '0)
			read_cnt <= read_cnt - 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Acknowledge pipeline
	//////////////////////////////////////////////////////////////////////

	// Everything except a core read acks two cycles out
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_dbg_cyc)
			pre_ack <= 1'b0;
		else
			pre_ack <= o_accept && !cpu_read;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_dbg_cyc)
			o_dbg_ack <= 1'b0;
		else
			o_dbg_ack <= pre_ack || (read_cnt == 'd1);
	end

	// Read data mux
	always_ff @(posedge i_clk)
	begin
		status_r <= i_status;
		if (!cmd_read)
			o_dbg_data <= status_r;
		// First cycle after accept, core data still from the read address
		else if (read_cnt == dbg_pkg::READ_WAIT)
			o_dbg_data <= i_reg_data;
	end

endmodule

//--- design/dbg_top.sv
`timescale 1ns/10ps

module dbg_top (
	input	logic				i_clk,
	input	logic				i_reset,
	input	logic				i_dbg_cyc,
	input	logic				i_dbg_stb,
	input	logic				i_dbg_we,
	input	logic [dbg_pkg::ADDR_W-1:0]	i_dbg_addr,
	input	logic [dbg_pkg::DATA_W-1:0]	i_dbg_data,
	input	logic [dbg_pkg::SEL_W-1:0]	i_dbg_sel,
	input	logic				i_ext_int,
	input	logic				i_cpu_fault,
	output	logic				o_dbg_stall,
	output	logic				o_dbg_ack,
	output	logic [dbg_pkg::DATA_W-1:0]	o_dbg_data
);

	dbg_pkg::dbg_req_t		req;
	dbg_pkg::core_cmd_t		cmd;
	dbg_pkg::core_stat_t		stat;
	logic				accept;
	logic	[dbg_pkg::DATA_W-1:0]	status;
	logic	[dbg_pkg::DATA_W-1:0]	reg_data;

	//////////////////////////////////////////////////////////////////////
	// Bus request bundle
	//////////////////////////////////////////////////////////////////////

	assign req = '{we: i_dbg_we, addr: i_dbg_addr, data: i_dbg_data, sel: i_dbg_sel};

	// Command and status state
	dbg_ctrl u_dbg_ctrl (
		.i_clk		(i_clk),
		.i_reset	(i_reset),
		.i_req		(req),
		.i_accept	(accept),
		.i_stat		(stat),
		.i_ext_int	(i_ext_int),
		.o_cmd		(cmd),
		.o_status	(status)
	);

	// Stall, ack and read data
	dbg_resp u_dbg_resp (
		.i_clk		(i_clk),
		.i_reset	(i_reset),
		.i_dbg_cyc	(i_dbg_cyc),
		.i_dbg_stb	(i_dbg_stb),
		.i_dbg_we	(i_dbg_we),
		.i_addr_sel	(i_dbg_addr[dbg_pkg::ADDR_W-1]),
		.i_write_wait	(stat.wr_stall),
		.i_status	(status),
		.i_reg_data	(reg_data),
		.o_accept	(accept),
		.o_dbg_stall	(o_dbg_stall),
		.o_dbg_ack	(o_dbg_ack),
		.o_dbg_data	(o_dbg_data)
	);

	// Core stand-in, read index straight off the bus
	core_regs u_core_regs (
		.i_clk		(i_clk),
		.i_cmd		(cmd),
		.i_rreg		(i_dbg_addr[dbg_pkg::REG_AW-1:0]),
		.i_fault	(i_cpu_fault),
		.o_stat		(stat),
		.o_rdata	(reg_data)
	);

endmodule

//--- sim/dbg_top_assertions.sv
`timescale 1ns/10ps

module dbg_top_assertions (
	input	logic	i_clk,
	input	logic	i_reset,
	input	logic	i_cyc,
	input	logic	i_ack,
	input	logic	i_read_accept,
	input	logic	i_stall,
	input	logic	i_step,
	input	logic	i_halt
);

	// Ack only while the cycle is open
	assert property (@(posedge i_clk) disable iff (i_reset) i_ack |-> i_cyc)
		else $error("ack raised without cyc");

	// Step pulse always runs with halt released
	assert property (@(posedge i_clk) disable iff (i_reset) !(i_step && i_halt))
		else $error("step and halt high together");

	// Core read stall over by the third cycle
	assert property (@(posedge i_clk) disable iff (i_reset)
		i_read_accept |-> ##3 !i_stall)
		else $error("stall held too long after read accept");

endmodule

// Control side, bus inputs tied idle
bind dbg_ctrl dbg_top_assertions u_ctrl_assertions (
	.i_clk(i_clk), .i_reset(i_reset), .i_cyc(1'b1), .i_ack(1'b0),
	.i_read_accept(1'b0), .i_stall(1'b0), .i_step(cmd_step), .i_halt(cmd_halt)
);

// Response side, control inputs tied idle
bind dbg_resp dbg_top_assertions u_resp_assertions (
	.i_clk(i_clk), .i_reset(i_reset), .i_cyc(i_dbg_cyc), .i_ack(o_dbg_ack),
	.i_read_accept(cpu_read), .i_stall(o_dbg_stall), .i_step(1'b0), .i_halt(1'b0)
);

//--- sim/tb_dbg_top.sv
`timescale 1ns/10ps

module tb_dbg_top;

	localparam int TIMEOUT_CYCLES = 4000;
	// Expected status words, halt + halted + int, with and without catch
	localparam logic [31:0] STAT_CATCH = 32'h0000_0423;
	localparam logic [31:0] STAT_NO_CATCH = 32'h0000_0403;

	logic		i_clk = 1'b0;
	logic		i_reset;
	logic		i_dbg_cyc, i_dbg_stb, i_dbg_we;
	logic	[5:0]	i_dbg_addr;
	logic	[31:0]	i_dbg_data;
	logic	[3:0]	i_dbg_sel;
	logic		i_ext_int, i_cpu_fault;
	logic		o_dbg_stall, o_dbg_ack;
	logic	[31:0]	o_dbg_data;

	integer		seed = 32'hc6c9079b;
	int		cycle_count = 0;
	logic	[31:0]	model_regs [0:31];
	logic	[31:0]	rdata;

	dbg_top u_dbg_top (.*);

	always #4 i_clk = !i_clk;

	////////////////////////////////////////////////////////////////////
	// Timeout and checking
	////////////////////////////////////////////////////////////////////

	always @(posedge i_clk)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the tests did not finish within %0d cycles",
				TIMEOUT_CYCLES);
			$display("Checks failed");
			$fatal(1);
		end
	end

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("CHECK FAILED: %s got %h expected %h", name, actual, expected);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	// Single access, waits out stall, counts edges from accept to ack
	task automatic bus_access(input logic we, input logic [5:0] addr, input logic [31:0] data,
			input int exp_delay, output logic [31:0] data_out);
		int delay;
		logic exp_stall;
		// Only a core register read holds stall until its ack
		exp_stall = !we && addr[5];
		@(posedge i_clk);
		#1;
		i_dbg_cyc = 1'b1;
		i_dbg_stb = 1'b1;
		i_dbg_we = we;
		i_dbg_addr = addr;
		i_dbg_data = data;
		i_dbg_sel = 4'hf;
		@(negedge i_clk);
		while (o_dbg_stall)
			@(negedge i_clk);
		@(posedge i_clk);
		#1;
		i_dbg_stb = 1'b0;
		i_dbg_we = 1'b0;
		delay = 1;
		@(negedge i_clk);
		while (!o_dbg_ack)
		begin
			check("o_dbg_stall", o_dbg_stall, exp_stall);
			delay++;
			@(negedge i_clk);
		end
		data_out = o_dbg_data;
		check("ack delay", delay, exp_delay);
		check("o_dbg_stall at ack", o_dbg_stall, 1'b0);
		// Idle bus between accesses
		@(posedge i_clk);
		#1;
		i_dbg_cyc = 1'b0;
	endtask

	// One cycle fault pulse, then let the core settle
	task automatic pulse_fault();
		@(posedge i_clk);
		#1;
		i_cpu_fault = 1'b1;
		@(posedge i_clk);
		#1;
		i_cpu_fault = 1'b0;
		repeat (10) @(posedge i_clk);
	endtask

	////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////

	initial
	begin
		int idx;
		int n_steps;
		logic [31:0] wval;
		i_reset = 1'b1;
		i_dbg_cyc = 1'b0;
		i_dbg_stb = 1'b0;
		i_dbg_we = 1'b0;
		i_dbg_addr = '0;
		i_dbg_data = '0;
		i_dbg_sel = '0;
		i_ext_int = 1'b1;
		i_cpu_fault = 1'b0;
		repeat (4) @(posedge i_clk);
		#1;
		i_reset = 1'b0;
		repeat (30) @(posedge i_clk);

		// Power-up status
		bus_access(1'b0, 6'h00, 32'h0, 2, rdata);
		check("status after reset", rdata, STAT_CATCH);

		// Random register writes with read back
		repeat (20)
		begin
			idx = $unsigned($random(seed)) % 31;
			wval = $random(seed);
			model_regs[idx] = wval;
			bus_access(1'b1, 6'h20 | idx[5:0], wval, 2, rdata);
			bus_access(1'b0, 6'h20 | idx[5:0], 32'h0, 3, rdata);
			check("register read back", rdata, model_regs[idx]);
		end

		// Core reset then single steps, catch kept set
		n_steps = 1 + ($unsigned($random(seed)) % 8);
		bus_access(1'b1, 6'h00, 32'h29, 2, rdata);
		model_regs[31] = 32'h1000_0000;
		repeat (n_steps)
		begin
			bus_access(1'b1, 6'h00, 32'h24, 2, rdata);
			model_regs[31] = model_regs[31] + 1;
		end
		bus_access(1'b0, 6'h3f, 32'h0, 3, rdata);
		check("pc after steps", rdata, model_regs[31]);

		// Fault with catch set halts the core
		bus_access(1'b1, 6'h00, 32'h20, 2, rdata);
		pulse_fault();
		bus_access(1'b0, 6'h00, 32'h0, 2, rdata);
		check("status after caught fault", rdata, STAT_CATCH);

		// Fault with catch clear resets the core
		bus_access(1'b1, 6'h00, 32'h00, 2, rdata);
		pulse_fault();
		bus_access(1'b0, 6'h3f, 32'h0, 3, rdata);
		check("pc after fault reset", rdata, 32'h1000_0000);
		bus_access(1'b0, 6'h00, 32'h0, 2, rdata);
		check("status after fault reset", rdata, STAT_NO_CATCH);

		$display("All checks passed");
		$finish;
	end

endmodule

//--- files.f
design/dbg_pkg.sv
design/core_regs.sv
design/dbg_ctrl.sv
design/dbg_resp.sv
design/dbg_top.sv
sim/dbg_top_assertions.sv
sim/tb_dbg_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the debug controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f files.f --top-module tb_dbg_top -o tb_dbg_top \
	&& ./obj_dir/tb_dbg_top | grep -F "All checks passed" \
	&& echo "Simulation PASSED" \
	|| { echo "Simulation FAILED"; exit 1; }
